/* design/kmac_entropy_pkg.sv */
// KMAC entropy generator package
// Widths, handshake structs, error codes, FSM states and the LFSR step rule
// shared by the generator blocks
package kmac_entropy_pkg;

  // Widths with a meaning of their own
  localparam int unsigned SeedW      = 32;
  localparam int unsigned RandW      = 64;
  localparam int unsigned TimerW     = 16;
  localparam int unsigned PrescalerW = 10;
  localparam int unsigned HashCntW   = 10;
  localparam int unsigned ErrInfoW   = 24;

  typedef logic [SeedW-1:0]      seed_word_t;
  typedef logic [RandW-1:0]      rand_data_t;
  typedef logic [TimerW-1:0]     timer_val_t;
  typedef logic [PrescalerW-1:0] prescaler_t;
  typedef logic [HashCntW-1:0]   hash_cnt_t;

  typedef enum logic [1:0] {
    EntropyModeNone = 2'd0,
    EntropyModeEdn  = 2'd1,
    EntropyModeSw   = 2'd2
  } entropy_mode_e;

  typedef enum logic [2:0] {
    ErrNone             = 3'd0,
    ErrWaitTimerExpired = 3'd1,
    ErrIncorrectMode    = 3'd2
  } err_code_e;

  // Control FSM states, plain binary
  typedef enum logic [2:0] {
    StRandReset            = 3'd0,
    StRandReady            = 3'd1,
    StRandEdn              = 3'd2,
    StSwSeedWait           = 3'd3,
    StRandGenerate         = 3'd4,
    StRandErrWaitExpired   = 3'd5,
    StRandErrIncorrectMode = 3'd6,
    StRandErr              = 3'd7
  } rand_st_e;

  typedef struct packed {
    logic                valid;
    err_code_e           code;
    logic [ErrInfoW-1:0] info;
  } entropy_err_t;

  typedef struct packed {
    prescaler_t prescaler;
    timer_val_t limit;
  } timer_cfg_t;

  typedef struct packed {
    logic       ack;
    seed_word_t data;
  } edn_rsp_t;

  // FSM to PRNG strobes
  typedef struct packed {
    logic seed_load;
    logic seed_ack;
    logic advance;
    logic data_update;
    logic valid_clear;
  } prng_ctrl_t;

  localparam rand_data_t LfsrTaps         = 64'hD800_0000_0000_0000;
  localparam rand_data_t LfsrNonZero      = 64'h5A5A_C3C3_0F0F_9669;
  localparam rand_data_t BufferResetValue = 64'hA3C1_5E27_8B04_D96F;

  // One Galois step, LSB shifted out selects the feedback mask
  function automatic rand_data_t lfsr_step(rand_data_t state);
    rand_data_t shifted;
    shifted = state >> 1;
    return state[0] ? (shifted ^ LfsrTaps) : shifted;
  endfunction

endpackage

/* design/entropy_ctrl_fsm.sv */
// Entropy control FSM
// Latches the entropy mode, sequences PRNG seeding from software or EDN,
// buffer updates and reseeds, and reports each error once
`timescale 1ns/1ps

module entropy_ctrl_fsm
  import kmac_entropy_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          entropy_ready_i,
  input  entropy_mode_e mode_i,
  input  logic          rand_consumed_i,
  input  logic          entropy_refresh_req_i,
  input  logic          threshold_hit_i,
  input  logic          seed_req_i,
  input  logic          seed_done_i,
  input  logic          seed_update_i,
  input  logic          edn_ack_i,
  input  logic          timer_expired_i,
  input  logic          timer_armed_i,
  input  timer_val_t    timer_count_i,
  input  logic          err_processed_i,
  output prng_ctrl_t    prng_ctrl_o,
  output logic          rand_valid_set_o,
  output logic          entropy_req_o,
  output entropy_mode_e mode_o,
  output logic          timer_enable_o,
  output logic          timer_update_o,
  output logic          threshold_clr_o,
  output entropy_err_t  err_o
);

  rand_st_e      state_q, state_d;
  entropy_mode_e mode_q;
  logic          mode_latch;

  ////////////////////////////////////////////////////////////////////////////
  // State and mode registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StRandReset;
    end else begin
      state_q <= state_d;
    end
  end

  // Mode is held from leaving reset until the FSM comes back to reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= EntropyModeNone;
    end else if (mode_latch) begin
      mode_q <= mode_i;
    end
  end

  assign mode_o = mode_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    mode_latch       = 1'b0;
    prng_ctrl_o      = '0;
    rand_valid_set_o = 1'b0;
    entropy_req_o    = 1'b0;
    timer_enable_o   = 1'b0;
    timer_update_o   = 1'b0;
    threshold_clr_o  = 1'b0;
    err_o            = '{valid: 1'b0, code: ErrNone, info: '0};

    case (state_q)
      StRandReset: begin
        if (entropy_ready_i) begin
          // Drop the dummy entropy and take the configured mode
          prng_ctrl_o.valid_clear = 1'b1;
          mode_latch              = 1'b1;
          if (mode_i == EntropyModeSw) begin
            prng_ctrl_o.seed_load = 1'b1;
            state_d               = StSwSeedWait;
          end else if (mode_i == EntropyModeEdn) begin
            prng_ctrl_o.seed_load = 1'b1;
            timer_update_o        = 1'b1;
            state_d               = StRandEdn;
          end else begin
            state_d = StRandErrIncorrectMode;
          end
        end else begin
          // Dummy entropy so the core can run before software is set up
          rand_valid_set_o = 1'b1;
        end
      end

      StRandReady: begin
        if (rand_consumed_i) begin
          prng_ctrl_o.advance     = 1'b1;
          prng_ctrl_o.data_update = 1'b1;
          prng_ctrl_o.valid_clear = 1'b1;
          state_d                 = StRandGenerate;
        end else if ((mode_q == EntropyModeEdn) &&
                     (entropy_refresh_req_i || threshold_hit_i)) begin
          // Reseed from EDN, current buffer stays valid meanwhile
          prng_ctrl_o.seed_load = 1'b1;
          timer_update_o        = 1'b1;
          threshold_clr_o       = 1'b1;
          state_d               = StRandEdn;
        end
      end

      StRandEdn: begin
        entropy_req_o  = seed_req_i;
        timer_enable_o = 1'b1;
        if (timer_expired_i && timer_armed_i) begin
          state_d = StRandErrWaitExpired;
        end else if (seed_done_i) begin
          prng_ctrl_o.advance     = 1'b1;
          prng_ctrl_o.data_update = 1'b1;
          prng_ctrl_o.valid_clear = 1'b1;
          state_d                 = StRandGenerate;
        end else if (edn_ack_i) begin
          prng_ctrl_o.seed_ack = 1'b1;
        end
      end

      StSwSeedWait: begin
        // One word per software pulse
        prng_ctrl_o.seed_ack = seed_req_i & seed_update_i;
        if (seed_done_i) begin
          prng_ctrl_o.advance     = 1'b1;
          prng_ctrl_o.data_update = 1'b1;
          prng_ctrl_o.valid_clear = 1'b1;
          state_d                 = StRandGenerate;
        end
      end

      StRandGenerate: begin
        // Buffer was loaded on the way in
        rand_valid_set_o = 1'b1;
        state_d          = StRandReady;
      end

      StRandErrWaitExpired: begin
        err_o   = '{valid: 1'b1, code: ErrWaitTimerExpired,
                    info: ErrInfoW'(timer_count_i)};
        state_d = StRandErr;
      end

      StRandErrIncorrectMode: begin
        err_o   = '{valid: 1'b1, code: ErrIncorrectMode, info: ErrInfoW'(mode_q)};
        state_d = StRandErr;
      end

      StRandErr: begin
        // Keep serving so a running hash can finish
        rand_valid_set_o        = 1'b1;
        prng_ctrl_o.advance     = rand_consumed_i;
        prng_ctrl_o.data_update = rand_consumed_i;
        if (err_processed_i) begin
          state_d = StRandReset;
        end
      end

      default: begin
        state_d = StRandReset;
      end
    endcase
  end

endmodule

/* design/entropy_wait_timer.sv */
// EDN wait timer
// Prescaled down-counter started on each EDN request phase, raises a
// sticky expired flag once the limit has run out
`timescale 1ns/1ps

module entropy_wait_timer
  import kmac_entropy_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  timer_cfg_t cfg_i,
  input  logic       enable_i,
  input  logic       update_i,
  output logic       expired_o,
  output logic       armed_o,
  output timer_val_t count_o
);

  prescaler_t presc_reload_q;
  prescaler_t presc_cnt_q;
  timer_val_t count_q;
  logic       tick;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_reload_q <= '0;
      armed_o        <= 1'b0;
    end else if (update_i) begin
      presc_reload_q <= cfg_i.prescaler;
      // Zero limit turns the timer off
      armed_o        <= |cfg_i.limit;
    end
  end

  // Prescaler wraps every reload+1 enabled cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_cnt_q <= '0;
    end else if (update_i) begin
      presc_cnt_q <= cfg_i.prescaler;
    end else if (enable_i) begin
      presc_cnt_q <= (presc_cnt_q == '0) ? presc_reload_q : presc_cnt_q - 1'b1;
    end
  end

  assign tick = enable_i && (presc_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q   <= '0;
      expired_o <= 1'b0;
    end else if (update_i) begin
      count_q   <= cfg_i.limit;
      expired_o <= 1'b0;
    end else if (tick) begin
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end else begin
        // Sticky until the next update
        expired_o <= 1'b1;
      end
    end
  end

  assign count_o = count_q;

endmodule

/* design/entropy_hash_counter.sv */
// Hash operation counter
// Counts completed key blocks and latches a threshold hit that asks the
// FSM for an EDN reseed
`timescale 1ns/1ps

module entropy_hash_counter
  import kmac_entropy_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      in_keyblock_i,
  input  logic      clr_i,
  input  logic      refresh_i,
  input  hash_cnt_t threshold_i,
  input  logic      threshold_clr_i,
  output hash_cnt_t hash_cnt_o,
  output logic      threshold_hit_o
);

  logic keyblock_q;
  logic cnt_en;
  logic cnt_clr;
  logic threshold_hit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      keyblock_q <= 1'b0;
    end else begin
      keyblock_q <= in_keyblock_i;
    end
  end

  // Falling edge marks the end of one hash operation
  assign cnt_en = keyblock_q && !in_keyblock_i;

  // Zero threshold never hits
  assign threshold_hit = (threshold_i != '0) && (hash_cnt_o >= threshold_i);
  assign cnt_clr       = clr_i || refresh_i || threshold_hit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hash_cnt_o <= '0;
    end else if (cnt_clr) begin
      hash_cnt_o <= '0;
    end else if (cnt_en) begin
      hash_cnt_o <= hash_cnt_o + 1'b1;
    end
  end

  // Hit held until the FSM starts the reseed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      threshold_hit_o <= 1'b0;
    end else if (threshold_clr_i) begin
      threshold_hit_o <= 1'b0;
    end else if (threshold_hit) begin
      threshold_hit_o <= 1'b1;
    end
  end

endmodule

/* design/entropy_prng.sv */
// Seedable PRNG with output buffer
// 64-bit Galois LFSR seeded word by word from software or EDN, with a
// buffered random output and its valid flag
`timescale 1ns/1ps

module entropy_prng
  import kmac_entropy_pkg::*;
#(
  parameter int unsigned SeedWords = 2
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  prng_ctrl_t    ctrl_i,
  input  entropy_mode_e mode_i,
  input  seed_word_t    sw_seed_i,
  input  seed_word_t    edn_seed_i,
  input  logic          rand_consumed_i,
  input  logic          valid_set_i,
  output logic          seed_req_o,
  output logic          seed_done_o,
  output rand_data_t    rand_data_o,
  output logic          rand_valid_o
);

  localparam int unsigned CntW = $clog2(SeedWords + 1);

  logic [CntW-1:0] seed_cnt_q;
  logic            seeding_q;
  logic            seed_take;
  logic            last_word;
  seed_word_t      seed_word;
  rand_data_t      lfsr_q, lfsr_seeded, lfsr_adv;

  ////////////////////////////////////////////////////////////////////////////
  // Seeding
  ////////////////////////////////////////////////////////////////////////////

  assign seed_word   = (mode_i == EntropyModeSw) ? sw_seed_i : edn_seed_i;
  assign seed_req_o  = seeding_q && (seed_cnt_q != CntW'(SeedWords));
  assign seed_done_o = seeding_q && (seed_cnt_q == CntW'(SeedWords));
  assign seed_take   = ctrl_i.seed_ack && seed_req_o;
  assign last_word   = seed_cnt_q == CntW'(SeedWords - 1);

  // New word enters at the bottom, older words move up
  assign lfsr_seeded = {lfsr_q[RandW-SeedW-1:0], seed_word};
  assign lfsr_adv    = lfsr_step(lfsr_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seeding_q  <= 1'b0;
      seed_cnt_q <= '0;
    end else if (ctrl_i.seed_load) begin
      seeding_q  <= 1'b1;
      seed_cnt_q <= '0;
    end else if (seed_take) begin
      seed_cnt_q <= seed_cnt_q + 1'b1;
    end else if (ctrl_i.data_update) begin
      // First buffer load ends the seeding phase
      seeding_q <= 1'b0;
    end
  end

  // An all-zero state would lock the LFSR
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LfsrNonZero;
    end else if (ctrl_i.seed_load) begin
      lfsr_q <= '0;
    end else if (seed_take) begin
      lfsr_q <= (last_word && lfsr_seeded == '0) ? LfsrNonZero : lfsr_seeded;
    end else if (ctrl_i.advance) begin
      lfsr_q <= lfsr_adv;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output buffer and valid
  ////////////////////////////////////////////////////////////////////////////

  // Buffer takes the state after this cycle's step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rand_data_o <= BufferResetValue;
    end else if (ctrl_i.data_update) begin
      rand_data_o <= lfsr_adv;
    end
  end

  // Set wins over both clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rand_valid_o <= 1'b0;
    end else if (valid_set_i) begin
      rand_valid_o <= 1'b1;
    end else if (ctrl_i.valid_clear || rand_consumed_i) begin
      rand_valid_o <= 1'b0;
    end
  end

endmodule

/* design/kmac_entropy_top.sv */
// KMAC entropy generator top level
// Holds the EDN request until acknowledged and ties the control FSM,
// wait timer, hash counter and PRNG together
`timescale 1ns/1ps

module kmac_entropy_top
  import kmac_entropy_pkg::*;
#(
  parameter int unsigned SeedWords = 2
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  edn_rsp_t      entropy_rsp_i,
  input  logic          rand_consumed_i,
  input  logic          in_keyblock_i,
  input  entropy_mode_e mode_i,
  input  logic          entropy_ready_i,
  input  logic          seed_update_i,
  input  seed_word_t    seed_data_i,
  input  logic          entropy_refresh_req_i,
  input  timer_cfg_t    timer_cfg_i,
  input  logic          hash_cnt_clr_i,
  input  hash_cnt_t     hash_threshold_i,
  input  logic          err_processed_i,
  output logic          entropy_req_o,
  output logic          rand_valid_o,
  output rand_data_t    rand_data_o,
  output hash_cnt_t     hash_cnt_o,
  output entropy_err_t  err_o
);

  prng_ctrl_t    prng_ctrl;
  entropy_mode_e mode_q;
  timer_val_t    timer_count;
  logic          fsm_req, req_hold_q, edn_ack;
  logic          seed_req, seed_done, valid_set;
  logic          timer_enable, timer_update, timer_expired, timer_armed;
  logic          threshold_hit, threshold_clr;

  // Request stays up until EDN answers, even if the FSM moved on
  assign entropy_req_o = fsm_req || req_hold_q;
  assign edn_ack       = entropy_rsp_i.ack && entropy_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_hold_q <= 1'b0;
    end else begin
      req_hold_q <= (req_hold_q || fsm_req) && !entropy_rsp_i.ack;
    end
  end

  entropy_ctrl_fsm u_ctrl_fsm (
    .clk_i, .rst_ni, .entropy_ready_i, .mode_i, .rand_consumed_i, .entropy_refresh_req_i,
    .threshold_hit_i(threshold_hit), .seed_req_i(seed_req), .seed_done_i(seed_done),
    .seed_update_i, .edn_ack_i(edn_ack), .timer_expired_i(timer_expired),
    .timer_armed_i(timer_armed), .timer_count_i(timer_count), .err_processed_i,
    .prng_ctrl_o(prng_ctrl), .rand_valid_set_o(valid_set), .entropy_req_o(fsm_req),
    .mode_o(mode_q), .timer_enable_o(timer_enable), .timer_update_o(timer_update),
    .threshold_clr_o(threshold_clr), .err_o
  );

  entropy_wait_timer u_wait_timer (
    .clk_i, .rst_ni, .cfg_i(timer_cfg_i), .enable_i(timer_enable), .update_i(timer_update),
    .expired_o(timer_expired), .armed_o(timer_armed), .count_o(timer_count)
  );

  entropy_hash_counter u_hash_counter (
    .clk_i, .rst_ni, .in_keyblock_i, .clr_i(hash_cnt_clr_i), .refresh_i(entropy_refresh_req_i),
    .threshold_i(hash_threshold_i), .threshold_clr_i(threshold_clr), .hash_cnt_o,
    .threshold_hit_o(threshold_hit)
  );

  entropy_prng #(.SeedWords(SeedWords)) u_prng (
    .clk_i, .rst_ni, .ctrl_i(prng_ctrl), .mode_i(mode_q), .sw_seed_i(seed_data_i),
    .edn_seed_i(entropy_rsp_i.data), .rand_consumed_i, .valid_set_i(valid_set),
    .seed_req_o(seed_req), .seed_done_o(seed_done), .rand_data_o, .rand_valid_o
  );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and power-on reset
// Free-running clock with an active-low reset held for a fixed cycle count
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, away from the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* test/kmac_entropy_assertions.sv */
// Handshake assertions for the KMAC entropy generator
// Bound into the top level to watch the EDN request, the one-cycle error
// pulse and the consume-to-valid latency
`timescale 1ns/1ps

module kmac_entropy_assertions
  import kmac_entropy_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     req_i,
  input logic     ack_i,
  input logic     err_valid_i,
  input logic     consumed_i,
  input logic     valid_i,
  input rand_st_e state_i
);

  // Request only drops after EDN took a word
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(req_i) |-> $past(req_i && ack_i))
    else $error("EDN request dropped without an acknowledge");

  // Each error reported in a single cycle
  err_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_valid_i |=> !err_valid_i)
    else $error("Error valid held for more than one cycle");

  // Consume in ready, low for one cycle, then the new buffer is valid
  valid_return: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(consumed_i && (state_i == StRandReady), 2) |-> valid_i && !$past(valid_i))
    else $error("Random valid did not return two cycles after a consume");

endmodule

bind kmac_entropy_top kmac_entropy_assertions u_assertions (
  .clk_i, .rst_ni, .req_i(entropy_req_o), .ack_i(entropy_rsp_i.ack),
  .err_valid_i(err_o.valid), .consumed_i(rand_consumed_i), .valid_i(rand_valid_o),
  .state_i(u_ctrl_fsm.state_q)
);

/* test/kmac_entropy_tb.sv */
// KMAC entropy generator testbench
// Table of cases covering software and EDN seeding, consumption, the wait
// timer, the incorrect-mode error and the hash threshold reseed
`timescale 1ns/1ps

module kmac_entropy_tb
  import kmac_entropy_pkg::*;
();

  localparam int unsigned SeedWords   = 2;
  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned NumCases    = 6;
  localparam int unsigned WaitLimit   = 100;

  typedef struct packed {
    entropy_mode_e              mode;
    seed_word_t [SeedWords-1:0] seeds;
    logic [3:0]                 consumes;
    timer_cfg_t                 timer;
    hash_cnt_t                  threshold;
    err_code_e                  exp_err;
  } case_t;

  logic          clk;
  logic          por_n;
  logic          tb_rst_n;
  logic          rst_n;
  edn_rsp_t      entropy_rsp;
  logic          rand_consumed;
  logic          in_keyblock;
  entropy_mode_e mode;
  logic          entropy_ready;
  logic          seed_update;
  seed_word_t    seed_data;
  logic          refresh_req;
  timer_cfg_t    timer_cfg;
  logic          hash_clr;
  hash_cnt_t     hash_threshold;
  logic          err_processed;
  logic          entropy_req;
  logic          rand_valid;
  rand_data_t    rand_data;
  hash_cnt_t     hash_cnt;
  entropy_err_t  err;
  case_t         cases [NumCases];
  string         names [NumCases];
  integer        seed;

  tb_clock_gen #(.PeriodNs(ClkPeriod), .ResetCycles(ResetCycles)) u_clock_gen (
    .clk_o(clk),
    .rst_no(por_n)
  );

  assign rst_n = por_n && tb_rst_n;

  kmac_entropy_top #(.SeedWords(SeedWords)) DUT (
    .clk_i(clk), .rst_ni(rst_n), .entropy_rsp_i(entropy_rsp),
    .rand_consumed_i(rand_consumed), .in_keyblock_i(in_keyblock), .mode_i(mode),
    .entropy_ready_i(entropy_ready), .seed_update_i(seed_update), .seed_data_i(seed_data),
    .entropy_refresh_req_i(refresh_req), .timer_cfg_i(timer_cfg), .hash_cnt_clr_i(hash_clr),
    .hash_threshold_i(hash_threshold), .err_processed_i(err_processed),
    .entropy_req_o(entropy_req), .rand_valid_o(rand_valid), .rand_data_o(rand_data),
    .hash_cnt_o(hash_cnt), .err_o(err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois step, bit 0 falls out and selects the tap mask
  function automatic rand_data_t model_next(rand_data_t s);
    rand_data_t r;
    r = {1'b0, s[RandW-1:1]};
    if (s[0]) begin
      r = r ^ LfsrTaps;
    end
    return r;
  endfunction

  function automatic case_t table_row(entropy_mode_e mode_v, seed_word_t s0, seed_word_t s1,
                                      int consumes, prescaler_t presc, timer_val_t limit,
                                      hash_cnt_t thr, err_code_e exp_err);
    case_t row;
    row.mode            = mode_v;
    row.seeds[0]        = s0;
    row.seeds[1]        = s1;
    row.consumes        = 4'(consumes);
    row.timer.prescaler = presc;
    row.timer.limit     = limit;
    row.threshold       = thr;
    row.exp_err         = exp_err;
    return row;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
    end
  endtask

  // All drives land 1 ns after the rising edge
  task automatic step;
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle;
    entropy_rsp    = '0;
    rand_consumed  = 1'b0;
    in_keyblock    = 1'b0;
    mode           = EntropyModeNone;
    entropy_ready  = 1'b0;
    seed_update    = 1'b0;
    seed_data      = '0;
    refresh_req    = 1'b0;
    timer_cfg      = '0;
    hash_clr       = 1'b0;
    hash_threshold = '0;
    err_processed  = 1'b0;
  endtask

  task automatic apply_reset;
    drive_idle();
    tb_rst_n = 1'b0;
    repeat (ResetCycles) step();
    tb_rst_n = 1'b1;
  endtask

  task automatic wait_valid(input string name);
    int n = 0;
    while (!rand_valid) begin
      if (n == WaitLimit) abort_run({name, ": random data never became valid"});
      step();
      n++;
    end
  endtask

  task automatic wait_req(input string name);
    int n = 0;
    while (!entropy_req) begin
      if (n == WaitLimit) abort_run({name, ": EDN request never came up"});
      step();
      n++;
    end
  endtask

  task automatic wait_err(input string name);
    int n = 0;
    while (!err.valid) begin
      if (n == WaitLimit) abort_run({name, ": no error was reported"});
      step();
      n++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One table row
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_case(input string name, input case_t tc);
    seed_word_t words [SeedWords];
    rand_data_t model;
    int         delay;
    apply_reset();
    mode           = tc.mode;
    timer_cfg      = tc.timer;
    hash_threshold = tc.threshold;
    // Dummy entropy right after reset
    step();
    check_value({name, " reset valid"}, 64'd1, 64'(rand_valid));
    check_value({name, " reset data"}, BufferResetValue, rand_data);
    entropy_ready = 1'b1;
    step();
    check_value({name, " valid dropped"}, 64'd0, 64'(rand_valid));
    if (tc.exp_err != ErrNone) begin
      wait_err(name);
      check_value({name, " error code"}, 64'(tc.exp_err), 64'(err.code));
      check_value({name, " error info"}, 64'd0, 64'(err.info));
      entropy_ready = 1'b0;
      // Error pulse is over, FSM now holds in its error state
      step();
      err_processed = 1'b1;
      step();
      err_processed = 1'b0;
      step();
      check_value({name, " valid after error"}, 64'd1, 64'(rand_valid));
      // Only the reset state reacts to ready again
      entropy_ready = 1'b1;
      step();
      check_value({name, " valid dropped again"}, 64'd0, 64'(rand_valid));
    end else begin
      for (int w = 0; w < SeedWords; w++) begin
        if (tc.mode == EntropyModeSw) begin
          words[w]    = tc.seeds[w];
          seed_data   = words[w];
          seed_update = 1'b1;
          step();
          seed_update = 1'b0;
        end else begin
          // EDN answers after a random back-pressure delay
          words[w] = $random(seed);
          delay    = $random(seed) & 3;
          wait_req(name);
          repeat (delay) step();
          entropy_rsp = '{ack: 1'b1, data: words[w]};
          step();
          entropy_rsp.ack = 1'b0;
        end
      end
      model = '0;
      for (int w = 0; w < SeedWords; w++) begin
        model = {model[RandW-SeedW-1:0], words[w]};
      end
      if (model == '0) model = LfsrNonZero;
      model = model_next(model);
      wait_valid(name);
      check_value({name, " seeded data"}, model, rand_data);
      for (int k = 0; k < int'(tc.consumes); k++) begin
        rand_consumed = 1'b1;
        step();
        rand_consumed = 1'b0;
        check_value({name, " valid after consume"}, 64'd0, 64'(rand_valid));
        wait_valid(name);
        model = model_next(model);
        check_value({name, " next data"}, model, rand_data);
      end
      // Key block ends count up to the threshold, then EDN is asked again
      for (int k = 1; k <= int'(tc.threshold); k++) begin
        in_keyblock = 1'b1;
        step();
        in_keyblock = 1'b0;
        step();
        check_value({name, " hash count"}, 64'(k), 64'(hash_cnt));
      end
      if (tc.threshold != '0) begin
        wait_req(name);
        check_value({name, " hash count cleared"}, 64'd0, 64'(hash_cnt));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed     = 32'h2cb7;
    tb_rst_n = 1'b1;
    drive_idle();
    names[0] = "sw_seed";
    cases[0] = table_row(EntropyModeSw, 32'h1234_5678, 32'h9ABC_DEF0, 3, 10'd0, 16'd0,
                         10'd0, ErrNone);
    names[1] = "sw_zero_seed";
    cases[1] = table_row(EntropyModeSw, 32'h0, 32'h0, 2, 10'd0, 16'd0, 10'd0, ErrNone);
    names[2] = "edn_seed";
    cases[2] = table_row(EntropyModeEdn, 32'h0, 32'h0, 2, 10'd0, 16'd0, 10'd0, ErrNone);
    names[3] = "edn_timeout";
    cases[3] = table_row(EntropyModeEdn, 32'h0, 32'h0, 0, 10'd1, 16'd3, 10'd0,
                         ErrWaitTimerExpired);
    names[4] = "bad_mode";
    cases[4] = table_row(EntropyModeNone, 32'h0, 32'h0, 0, 10'd0, 16'd0, 10'd0,
                         ErrIncorrectMode);
    names[5] = "hash_threshold";
    cases[5] = table_row(EntropyModeEdn, 32'h0, 32'h0, 0, 10'd0, 16'd0, 10'd3, ErrNone);
    wait (por_n);
    step();
    for (int i = 0; i < NumCases; i++) begin
      run_case(names[i], cases[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

  // 200 cycles per row plus the power-on reset
  initial begin
    #((NumCases * 200 + ResetCycles) * ClkPeriod);
    abort_run("Watchdog expired before all cases finished");
  end

endmodule

/* flist.f */
design/kmac_entropy_pkg.sv
design/entropy_ctrl_fsm.sv
design/entropy_wait_timer.sv
design/entropy_hash_counter.sv
design/entropy_prng.sv
design/kmac_entropy_top.sv
test/tb_clock_gen.sv
test/kmac_entropy_assertions.sv
test/kmac_entropy_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= kmac_entropy_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
